// File: source/dem_uart_macros.svh
`ifndef DEM_UART_MACROS_SVH
`define DEM_UART_MACROS_SVH

// Flit and id widths of the debug network.
`define FLIT_W 16
`define ID_W 10

// Identity and version of this module.
`define DEM_MODID 16'h0002
`define DEM_MODVERSION 16'h0000

// Register map.
`define REG_ADDR_MODID 16'h0000
`define REG_ADDR_VERSION 16'h0001
`define REG_ADDR_CTRL 16'h0003

// Type field sits above the subtype, the source id fills the low bits.
`define HDR_TYPE_MSB 15
`define HDR_SUB_MSB 13

`endif

// File: source/dem_uart_pkg.sv
package dem_uart_pkg;

   // Packet type field of header flit 1.
   typedef enum logic [1:0] {
      REG   = 2'd0,
      EVENT = 2'd1
   } pkt_type_e;

   // Register access subtypes. Event subtype 1 carries a character.
   typedef enum logic [3:0] {
      READ16   = 4'h0,
      WRITE16  = 4'h4,
      RESP_OK  = 4'h8,
      RESP_ERR = 4'hc
   } reg_sub_e;

   typedef enum logic [1:0] {
      TX_DEST,
      TX_SRC,
      TX_DATA
   } tx_state_e;

   typedef enum logic [1:0] {
      RX_DEST,
      RX_HDR,
      RX_PAYLOAD,
      RX_DROP
   } rx_state_e;

   // Incoming parse states, then response states.
   typedef enum logic [2:0] {
      IDLE,
      HDR,
      ADDR,
      WDATA,
      RESP_DEST,
      RESP_HDR,
      RESP_DATA
   } acc_state_e;

endpackage

// File: source/uart_tx_packetizer.sv
`include "dem_uart_macros.svh"

module uart_tx_packetizer (
   input  logic               clk,
   input  logic               rst,
   input  logic [`ID_W-1:0]   id,
   input  logic               stall,
   input  logic [7:0]         out_char,
   input  logic               out_valid,
   output logic               out_ready,
   output logic [`FLIT_W-1:0] ev_data,
   output logic               ev_last,
   output logic               ev_valid,
   input  logic               ev_ready
);
   import dem_uart_pkg::*;

   tx_state_e state;
   logic      held;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= TX_DEST;
         held <= 1'b0;
      end else begin
         // Once offered, the first flit stays up even if stall rises.
         held <= (state == TX_DEST) && ev_valid && !ev_ready;
         case (state)
            TX_DEST: begin
               if (ev_valid && ev_ready) begin
                  state <= TX_SRC;
               end
            end
            TX_SRC: begin
               if (ev_ready) begin
                  state <= TX_DATA;
               end
            end
            TX_DATA: begin
               if (ev_ready) begin
                  state <= TX_DEST;
               end
            end
            default: state <= TX_DEST;
         endcase
      end
   end

   always_comb begin
      ev_valid = 1'b0;
      ev_last = 1'b0;
      ev_data = '0;
      out_ready = 1'b0;
      case (state)
         TX_DEST: begin
            // Events always go to the host at id 0.
            ev_valid = out_valid && (!stall || held);
         end
         TX_SRC: begin
            ev_valid = 1'b1;
            ev_data = {EVENT, 4'h1, id};
         end
         TX_DATA: begin
            ev_valid = 1'b1;
            ev_last = 1'b1;
            ev_data = {8'h00, out_char};
            out_ready = ev_ready;
         end
         default: ;
      endcase
   end

endmodule

// File: source/uart_rx_depacketizer.sv
`include "dem_uart_macros.svh"

module uart_rx_depacketizer (
   input  logic               clk,
   input  logic               rst,
   input  logic [`FLIT_W-1:0] rx_data,
   input  logic               rx_last,
   input  logic               rx_valid,
   output logic               rx_ready,
   output logic [7:0]         in_char,
   output logic               in_valid,
   input  logic               in_ready
);
   import dem_uart_pkg::*;

   rx_state_e  state;
   logic       full;
   logic [7:0] char_q;
   logic       rx_xfer;

   // One character of buffering.
   assign rx_ready = !full;
   assign rx_xfer = rx_valid && rx_ready;
   assign in_valid = full;
   assign in_char = char_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= RX_DEST;
         full <= 1'b0;
      end else begin
         if (in_valid && in_ready) begin
            full <= 1'b0;
         end
         if (rx_xfer) begin
            case (state)
               RX_DEST: begin
                  if (!rx_last) begin
                     state <= RX_HDR;
                  end
               end
               RX_HDR: begin
                  state <= rx_last ? RX_DEST : RX_PAYLOAD;
               end
               RX_PAYLOAD: begin
                  full <= 1'b1;
                  state <= rx_last ? RX_DEST : RX_DROP;
               end
               RX_DROP: begin
                  if (rx_last) begin
                     state <= RX_DEST;
                  end
               end
               default: state <= RX_DEST;
            endcase
         end
      end
   end

   // Character byte of the first payload flit.
   always_ff @(posedge clk) begin
      if (rx_xfer && (state == RX_PAYLOAD)) begin
         char_q <= rx_data[7:0];
      end
   end

endmodule

// File: source/dbg_reg_access.sv
`include "dem_uart_macros.svh"

module dbg_reg_access (
   input  logic               clk,
   input  logic               rst,
   input  logic [`ID_W-1:0]   id,
   input  logic [`FLIT_W-1:0] debug_in_data,
   input  logic               debug_in_last,
   input  logic               debug_in_valid,
   output logic               debug_in_ready,
   output logic [`FLIT_W-1:0] debug_out_data,
   output logic               debug_out_last,
   output logic               debug_out_valid,
   input  logic               debug_out_ready,
   input  logic [`FLIT_W-1:0] ev_data,
   input  logic               ev_last,
   input  logic               ev_valid,
   output logic               ev_ready,
   output logic [`FLIT_W-1:0] rx_data,
   output logic               rx_last,
   output logic               rx_valid,
   input  logic               rx_ready,
   output logic               stall
);
   import dem_uart_pkg::*;

   acc_state_e         state;
   logic               dest_hit;
   logic               fwd;
   logic               dest_sent;
   logic               is_req;
   logic               extra;
   logic               resp_ok;
   logic               resp_has_data;
   logic               own_ev;
   logic [`FLIT_W-1:0] ctrl;
   reg_sub_e           req_sub;
   logic [`ID_W-1:0]   req_src;
   logic [`FLIT_W-1:0] req_addr;
   logic [`FLIT_W-1:0] resp_data;

   logic [`FLIT_W-1:0] own_dest;
   logic [1:0]         in_type;
   logic [3:0]         in_sub;
   logic               in_xfer;
   logic               rx_xfer;
   logic               hdr_fwd;
   logic               hdr_req;
   logic               rd_hit;
   logic [`FLIT_W-1:0] rd_val;
   logic               wr_ok;
   logic               resp_active;
   logic               resp_xfer;
   reg_sub_e           resp_sub;
   logic [`FLIT_W-1:0] resp_flit;
   logic               resp_last;

   assign own_dest = {{(`FLIT_W-`ID_W){1'b0}}, id};
   assign in_type = debug_in_data[`HDR_TYPE_MSB -: 2];
   assign in_sub = debug_in_data[`HDR_SUB_MSB -: 4];
   assign in_xfer = debug_in_valid && debug_in_ready;
   assign rx_xfer = rx_valid && rx_ready;

   // Sorting at the header flit.
   assign hdr_fwd = (state == HDR) && debug_in_valid && dest_hit && (in_type == EVENT);
   assign hdr_req = dest_hit && (in_type == REG) && ((in_sub == READ16) || (in_sub == WRITE16));

   assign resp_active = (state == RESP_DEST) || (state == RESP_HDR) || (state == RESP_DATA);
   assign resp_xfer = resp_active && !own_ev && debug_out_ready;
   assign resp_sub = resp_ok ? RESP_OK : RESP_ERR;
   assign wr_ok = (req_sub == WRITE16) && !extra && (req_addr == `REG_ADDR_CTRL);
   assign stall = !ctrl[0];

   always_comb begin
      rd_hit = 1'b1;
      rd_val = ctrl;
      case (debug_in_data)
         `REG_ADDR_MODID:   rd_val = `DEM_MODID;
         `REG_ADDR_VERSION: rd_val = `DEM_MODVERSION;
         `REG_ADDR_CTRL:    rd_val = ctrl;
         default:           rd_hit = 1'b0;
      endcase
   end

   // Incoming side. Forwarded events get their dest flit rebuilt from id.
   always_comb begin
      debug_in_ready = 1'b0;
      rx_valid = 1'b0;
      rx_data = debug_in_data;
      rx_last = debug_in_last;
      case (state)
         IDLE, ADDR, WDATA: begin
            if (fwd) begin
               rx_valid = debug_in_valid;
               debug_in_ready = rx_ready;
            end else begin
               debug_in_ready = 1'b1;
            end
         end
         HDR: begin
            if (hdr_fwd && !dest_sent) begin
               rx_valid = 1'b1;
               rx_data = own_dest;
               rx_last = 1'b0;
            end else if (hdr_fwd) begin
               rx_valid = 1'b1;
               debug_in_ready = rx_ready;
            end else begin
               debug_in_ready = 1'b1;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         dest_hit <= 1'b0;
         fwd <= 1'b0;
         dest_sent <= 1'b0;
         is_req <= 1'b0;
         extra <= 1'b0;
         resp_ok <= 1'b0;
         resp_has_data <= 1'b0;
         ctrl <= 16'h0001;
      end else begin
         case (state)
            IDLE: begin
               if (in_xfer) begin
                  dest_hit <= (debug_in_data == own_dest);
                  if (!debug_in_last) begin
                     state <= HDR;
                  end
               end
            end
            HDR: begin
               if (hdr_fwd && !dest_sent && rx_xfer) begin
                  dest_sent <= 1'b1;
               end
               if (in_xfer) begin
                  dest_sent <= 1'b0;
                  fwd <= hdr_fwd && !debug_in_last;
                  is_req <= hdr_req;
                  extra <= 1'b0;
                  if (!debug_in_last) begin
                     state <= ADDR;
                  end else if (hdr_req) begin
                     // Request without address.
                     resp_ok <= 1'b0;
                     resp_has_data <= 1'b0;
                     state <= RESP_DEST;
                  end else begin
                     state <= IDLE;
                  end
               end
            end
            ADDR: begin
               if (in_xfer) begin
                  if (!debug_in_last) begin
                     state <= WDATA;
                  end else if (fwd || !is_req) begin
                     fwd <= 1'b0;
                     state <= IDLE;
                  end else begin
                     resp_ok <= (req_sub == READ16) && rd_hit;
                     resp_has_data <= (req_sub == READ16) && rd_hit;
                     state <= RESP_DEST;
                  end
               end
            end
            WDATA: begin
               if (in_xfer) begin
                  if (!debug_in_last) begin
                     extra <= 1'b1;
                  end else if (is_req) begin
                     resp_ok <= wr_ok;
                     resp_has_data <= 1'b0;
                     if (wr_ok) begin
                        ctrl <= debug_in_data;
                     end
                     state <= RESP_DEST;
                  end else begin
                     fwd <= 1'b0;
                     state <= IDLE;
                  end
               end
            end
            RESP_DEST: begin
               if (resp_xfer) begin
                  state <= RESP_HDR;
               end
            end
            RESP_HDR: begin
               if (resp_xfer) begin
                  if (resp_has_data) begin
                     state <= RESP_DATA;
                  end else begin
                     state <= IDLE;
                  end
               end
            end
            RESP_DATA: begin
               if (resp_xfer) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == HDR) && in_xfer) begin
         req_src <= debug_in_data[`ID_W-1:0];
         req_sub <= reg_sub_e'(in_sub);
      end
      if ((state == ADDR) && in_xfer) begin
         req_addr <= debug_in_data;
         resp_data <= rd_val;
      end
   end

   always_comb begin
      resp_flit = {{(`FLIT_W-`ID_W){1'b0}}, req_src};
      resp_last = 1'b0;
      case (state)
         RESP_HDR: begin
            resp_flit = {REG, resp_sub, id};
            resp_last = !resp_has_data;
         end
         RESP_DATA: begin
            resp_flit = resp_data;
            resp_last = 1'b1;
         end
         default: ;
      endcase
   end

   // Output owner. An offered event keeps the port until its last flit.
   always_ff @(posedge clk) begin
      if (rst) begin
         own_ev <= 1'b0;
      end else if (!own_ev && !resp_active && ev_valid) begin
         own_ev <= 1'b1;
      end else if (own_ev && ev_valid && ev_last && debug_out_ready) begin
         own_ev <= 1'b0;
      end
   end

   always_comb begin
      if (resp_active && !own_ev) begin
         debug_out_valid = 1'b1;
         debug_out_data = resp_flit;
         debug_out_last = resp_last;
         ev_ready = 1'b0;
      end else begin
         debug_out_valid = ev_valid;
         debug_out_data = ev_data;
         debug_out_last = ev_last;
         ev_ready = debug_out_ready;
      end
   end

endmodule

// File: source/dem_uart_top.sv
`include "dem_uart_macros.svh"

module dem_uart_top (
   input  logic               clk,
   input  logic               rst,
   input  logic [`FLIT_W-1:0] debug_in_data,
   input  logic               debug_in_last,
   input  logic               debug_in_valid,
   output logic               debug_in_ready,
   output logic [`FLIT_W-1:0] debug_out_data,
   output logic               debug_out_last,
   output logic               debug_out_valid,
   input  logic               debug_out_ready,
   input  logic [`ID_W-1:0]   id,
   input  logic [7:0]         out_char,
   input  logic               out_valid,
   output logic               out_ready,
   output logic [7:0]         in_char,
   output logic               in_valid,
   input  logic               in_ready
);

   // Packetizer to register access stage.
   logic [`FLIT_W-1:0] ev_data;
   logic               ev_last;
   logic               ev_valid;
   logic               ev_ready;

   // Register access stage to depacketizer.
   logic [`FLIT_W-1:0] rx_data;
   logic               rx_last;
   logic               rx_valid;
   logic               rx_ready;

   logic               stall;

   uart_tx_packetizer tx_i (
      .clk      (clk),
      .rst      (rst),
      .id       (id),
      .stall    (stall),
      .out_char (out_char),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .ev_data  (ev_data),
      .ev_last  (ev_last),
      .ev_valid (ev_valid),
      .ev_ready (ev_ready)
   );

   dbg_reg_access acc_i (
      .clk            (clk),
      .rst            (rst),
      .id             (id),
      .debug_in_data  (debug_in_data),
      .debug_in_last  (debug_in_last),
      .debug_in_valid (debug_in_valid),
      .debug_in_ready (debug_in_ready),
      .debug_out_data (debug_out_data),
      .debug_out_last (debug_out_last),
      .debug_out_valid(debug_out_valid),
      .debug_out_ready(debug_out_ready),
      .ev_data        (ev_data),
      .ev_last        (ev_last),
      .ev_valid       (ev_valid),
      .ev_ready       (ev_ready),
      .rx_data        (rx_data),
      .rx_last        (rx_last),
      .rx_valid       (rx_valid),
      .rx_ready       (rx_ready),
      .stall          (stall)
   );

   uart_rx_depacketizer rx_i (
      .clk     (clk),
      .rst     (rst),
      .rx_data (rx_data),
      .rx_last (rx_last),
      .rx_valid(rx_valid),
      .rx_ready(rx_ready),
      .in_char (in_char),
      .in_valid(in_valid),
      .in_ready(in_ready)
   );

endmodule

// File: verif/dem_uart_sva.sv
`include "dem_uart_macros.svh"

module dem_uart_sva (
   input logic               clk,
   input logic               rst,
   input logic [`FLIT_W-1:0] debug_out_data,
   input logic               debug_out_last,
   input logic               debug_out_valid,
   input logic               debug_out_ready,
   input logic               debug_in_ready,
   input logic [7:0]         in_char,
   input logic               in_valid,
   input logic               in_ready,
   input logic               out_ready
);

   // Network output holds its flit until it is taken.
   out_hold: assert property (@(posedge clk) disable iff (rst)
      debug_out_valid && !debug_out_ready |=>
         debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last))
      else $error("debug_out flit changed before it was taken");

   // Character to the system holds until taken.
   char_hold: assert property (@(posedge clk) disable iff (rst)
      in_valid && !in_ready |=> in_valid && $stable(in_char))
      else $error("in_char changed before it was taken");

   // Idle handshake outputs after reset.
   rst_values: assert property (@(posedge clk)
      rst |=> !debug_out_valid && !in_valid && !out_ready && debug_in_ready)
      else $error("handshake outputs not at reset values");

endmodule

// File: verif/dem_uart_tb.sv
`include "dem_uart_macros.svh"

module dem_uart_tb;
   import dem_uart_pkg::*;

   localparam logic [`ID_W-1:0] DUT_ID = 10'h005;
   localparam logic [31:0] SEED = 32'h169a40a0;
   // About four times the length of all tests.
   localparam int MAX_CYCLES = 4000;

   // Flit with its last flag in the top bit.
   typedef logic [`FLIT_W:0] flit_q_t[$];

   logic               clk = 1'b0;
   logic               rst;
   logic [`FLIT_W-1:0] debug_in_data;
   logic               debug_in_last;
   logic               debug_in_valid;
   logic               debug_in_ready;
   logic [`FLIT_W-1:0] debug_out_data;
   logic               debug_out_last;
   logic               debug_out_valid;
   logic               debug_out_ready = 1'b1;
   logic [7:0]         out_char;
   logic               out_valid;
   logic               out_ready;
   logic [7:0]         in_char;
   logic               in_valid;
   logic               in_ready = 1'b1;

   logic               random_ready;
   logic [`FLIT_W-1:0] model_ctrl;
   int                 cycles = 0;
   string              test_name;
   flit_q_t            exp_ev;
   flit_q_t            exp_resp;
   flit_q_t            cur_pkt;
   logic [7:0]         exp_char[$];

   always #50 clk = ~clk;

   dem_uart_top dut_i (
      .clk            (clk),
      .rst            (rst),
      .debug_in_data  (debug_in_data),
      .debug_in_last  (debug_in_last),
      .debug_in_valid (debug_in_valid),
      .debug_in_ready (debug_in_ready),
      .debug_out_data (debug_out_data),
      .debug_out_last (debug_out_last),
      .debug_out_valid(debug_out_valid),
      .debug_out_ready(debug_out_ready),
      .id             (DUT_ID),
      .out_char       (out_char),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .in_char        (in_char),
      .in_valid       (in_valid),
      .in_ready       (in_ready)
   );

   bind dem_uart_top dem_uart_sva sva_i (
      .clk            (clk),
      .rst            (rst),
      .debug_out_data (debug_out_data),
      .debug_out_last (debug_out_last),
      .debug_out_valid(debug_out_valid),
      .debug_out_ready(debug_out_ready),
      .debug_in_ready (debug_in_ready),
      .in_char        (in_char),
      .in_valid       (in_valid),
      .in_ready       (in_ready),
      .out_ready      (out_ready)
   );

   task automatic stop_run();
      $display("tests failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_error(input string msg);
      $display("Error in %s: %s", test_name, msg);
      stop_run();
   endtask

   task automatic check_flit(input logic [`FLIT_W-1:0] exp_data, input logic exp_last,
                             input logic [`FLIT_W-1:0] act_data, input logic act_last);
      if (exp_data !== act_data || exp_last !== act_last) begin
         $display("Fail %s: expected flit %h last %b, actual flit %h last %b",
                  test_name, exp_data, exp_last, act_data, act_last);
         stop_run();
      end
   endtask

   task automatic check_char(input logic [7:0] exp_c, input logic [7:0] act_c);
      if (exp_c !== act_c) begin
         $display("Fail %s: expected char %h, actual char %h", test_name, exp_c, act_c);
         stop_run();
      end
   endtask

   // Expected packet. data is the character for events, the control value for requests.
   function automatic flit_q_t expected_packet(input pkt_type_e kind, input reg_sub_e sub,
                                               input logic [`ID_W-1:0] src,
                                               input logic [`FLIT_W-1:0] addr,
                                               input logic [`FLIT_W-1:0] data);
      flit_q_t            q;
      logic [`FLIT_W-1:0] rd;
      logic               known;
      known = 1'b1;
      case (addr)
         `REG_ADDR_MODID:   rd = `DEM_MODID;
         `REG_ADDR_VERSION: rd = `DEM_MODVERSION;
         `REG_ADDR_CTRL:    rd = data;
         default: begin
            known = 1'b0;
            rd = '0;
         end
      endcase
      if (kind == EVENT) begin
         q.push_back({1'b0, {`FLIT_W{1'b0}}});
         q.push_back({1'b0, EVENT, 4'h1, DUT_ID});
         q.push_back({1'b1, 8'h00, data[7:0]});
      end else begin
         q.push_back({1'b0, {(`FLIT_W-`ID_W){1'b0}}, src});
         if (sub == READ16 && known) begin
            q.push_back({1'b0, REG, RESP_OK, DUT_ID});
            q.push_back({1'b1, rd});
         end else if (sub == WRITE16 && addr == `REG_ADDR_CTRL) begin
            q.push_back({1'b1, REG, RESP_OK, DUT_ID});
         end else begin
            q.push_back({1'b1, REG, RESP_ERR, DUT_ID});
         end
      end
      return q;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic wait_drained();
      while (exp_ev.size() != 0 || exp_resp.size() != 0 || exp_char.size() != 0) begin
         @(posedge clk);
      end
      next_cycle();
   endtask

   task automatic queue_response(input reg_sub_e sub, input logic [`ID_W-1:0] src,
                                 input logic [`FLIT_W-1:0] addr);
      flit_q_t pkt;
      pkt = expected_packet(REG, sub, src, addr, model_ctrl);
      foreach (pkt[i]) begin
         exp_resp.push_back(pkt[i]);
      end
   endtask

   task automatic send_packet(input flit_q_t pkt);
      foreach (pkt[i]) begin
         debug_in_valid = 1'b1;
         debug_in_data = pkt[i][`FLIT_W-1:0];
         debug_in_last = pkt[i][`FLIT_W];
         @(negedge clk);
         while (!debug_in_ready) begin
            @(negedge clk);
         end
         next_cycle();
      end
      debug_in_valid = 1'b0;
   endtask

   task automatic read_reg(input logic [`ID_W-1:0] src, input logic [`FLIT_W-1:0] addr);
      flit_q_t pkt;
      queue_response(READ16, src, addr);
      pkt.push_back({1'b0, {(`FLIT_W-`ID_W){1'b0}}, DUT_ID});
      pkt.push_back({1'b0, REG, READ16, src});
      pkt.push_back({1'b1, addr});
      send_packet(pkt);
   endtask

   task automatic write_reg(input logic [`ID_W-1:0] src, input logic [`FLIT_W-1:0] addr,
                            input logic [`FLIT_W-1:0] value);
      flit_q_t pkt;
      queue_response(WRITE16, src, addr);
      if (addr == `REG_ADDR_CTRL) begin
         model_ctrl = value;
      end
      pkt.push_back({1'b0, {(`FLIT_W-`ID_W){1'b0}}, DUT_ID});
      pkt.push_back({1'b0, REG, WRITE16, src});
      pkt.push_back({1'b0, addr});
      pkt.push_back({1'b1, value});
      send_packet(pkt);
   endtask

   // Event from the host, id 0.
   task automatic send_event(input logic [`ID_W-1:0] dest, input logic [7:0] c);
      flit_q_t pkt;
      if (dest == DUT_ID) begin
         exp_char.push_back(c);
      end
      pkt.push_back({1'b0, {(`FLIT_W-`ID_W){1'b0}}, dest});
      pkt.push_back({1'b0, EVENT, 4'h1, {`ID_W{1'b0}}});
      pkt.push_back({1'b1, 8'h00, c});
      send_packet(pkt);
   endtask

   task automatic send_char(input logic [7:0] c);
      flit_q_t pkt;
      pkt = expected_packet(EVENT, READ16, '0, '0, {8'h00, c});
      foreach (pkt[i]) begin
         exp_ev.push_back(pkt[i]);
      end
      out_valid = 1'b1;
      out_char = c;
      @(negedge clk);
      while (!out_ready) begin
         @(negedge clk);
      end
      next_cycle();
      out_valid = 1'b0;
   endtask

   task automatic compare_packet(input flit_q_t pkt);
      logic [`FLIT_W:0] want;
      logic             is_event;
      is_event = (pkt.size() > 1) && (pkt[1][`HDR_TYPE_MSB -: 2] == EVENT);
      foreach (pkt[i]) begin
         if (is_event) begin
            if (exp_ev.size() == 0) begin
               report_error("an event packet arrived that was not expected");
            end
            want = exp_ev.pop_front();
         end else begin
            if (exp_resp.size() == 0) begin
               report_error("a response packet arrived that was not expected");
            end
            want = exp_resp.pop_front();
         end
         check_flit(want[`FLIT_W-1:0], want[`FLIT_W], pkt[i][`FLIT_W-1:0], pkt[i][`FLIT_W]);
      end
   endtask

   // Transfers are taken at the next rising edge.
   always @(negedge clk) begin
      if (!rst && debug_out_valid && debug_out_ready) begin
         cur_pkt.push_back({debug_out_last, debug_out_data});
         if (debug_out_last) begin
            compare_packet(cur_pkt);
            cur_pkt.delete();
         end
      end
      if (!rst && in_valid && in_ready) begin
         if (exp_char.size() == 0) begin
            report_error("a character arrived on in_char that was not expected");
         end
         check_char(exp_char.pop_front(), in_char);
      end
   end

   always @(posedge clk) begin
      #5;
      if (random_ready) begin
         debug_out_ready = 1'($urandom);
         in_ready = ($urandom % 4) != 0;
      end else begin
         debug_out_ready = 1'b1;
         in_ready = 1'b1;
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         report_error("the run hit the cycle limit, a handshake never completed");
      end
   end

   initial begin
      logic [7:0] held_char;
      void'($urandom(SEED));
      rst = 1'b1;
      debug_in_data = '0;
      debug_in_last = 1'b0;
      debug_in_valid = 1'b0;
      out_char = '0;
      out_valid = 1'b0;
      random_ready = 1'b0;
      model_ctrl = 16'h0001;
      test_name = "reset";
      repeat (10) begin
         @(posedge clk);
      end
      #5;
      rst = 1'b0;
      next_cycle();
      next_cycle();

      test_name = "tx events";
      for (int k = 0; k < 20; k++) begin
         send_char(8'($urandom));
      end
      wait_drained();

      test_name = "rx events";
      for (int k = 0; k < 9; k++) begin
         if (k % 3 == 2) begin
            send_event(10'h007, 8'($urandom));
         end else begin
            send_event(DUT_ID, 8'($urandom));
         end
      end
      wait_drained();

      test_name = "register reads";
      read_reg(10'h011, `REG_ADDR_MODID);
      read_reg(10'h022, `REG_ADDR_VERSION);
      read_reg(10'h033, 16'h0007);
      wait_drained();

      test_name = "control stall";
      write_reg(10'h044, `REG_ADDR_CTRL, 16'h0000);
      wait_drained();
      held_char = 8'($urandom);
      fork
         send_char(held_char);
      join_none
      repeat (30) begin
         @(negedge clk);
         if (out_ready || debug_out_valid) begin
            report_error("an event left the block while events were stalled");
         end
      end
      next_cycle();
      write_reg(10'h044, `REG_ADDR_CTRL, 16'h0001);
      wait fork;
      wait_drained();

      test_name = "random traffic";
      random_ready = 1'b1;
      fork
         begin
            for (int k = 0; k < 12; k++) begin
               send_char(8'($urandom));
               repeat ($urandom % 3) begin
                  next_cycle();
               end
            end
         end
         begin
            for (int k = 0; k < 15; k++) begin
               case (k % 5)
                  0: read_reg(10'($urandom), `REG_ADDR_MODID);
                  1: send_event(DUT_ID, 8'($urandom));
                  2: write_reg(10'($urandom), `REG_ADDR_CTRL, 16'h0001);
                  3: read_reg(10'($urandom), `REG_ADDR_CTRL);
                  default: write_reg(10'($urandom), `REG_ADDR_MODID, 16'h1234);
               endcase
            end
         end
      join
      wait_drained();
      random_ready = 1'b0;

      test_name = "end of run";
      if (exp_ev.size() != 0 || exp_resp.size() != 0 || exp_char.size() != 0 ||
          cur_pkt.size() != 0) begin
         report_error("expected output never arrived");
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

// File: filelist.f
+incdir+source
source/dem_uart_pkg.sv
source/uart_tx_packetizer.sv
source/uart_rx_depacketizer.sv
source/dbg_reg_access.sv
source/dem_uart_top.sv
verif/dem_uart_sva.sv
verif/dem_uart_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module dem_uart_tb \
   -o dem_uart_sim > build.log 2>&1 || { cat build.log; echo "Build FAILED"; exit 1; }
./obj_dir/dem_uart_sim > sim.log 2>&1
status=$?
cat sim.log
grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
[ "$status" -eq 0 ] && grep -q "all tests passed" sim.log && { echo "Simulation PASSED"; exit 0; }
echo "Simulation FAILED, the run ended early"
exit 1
